/* Bender.yml */
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/replay_fifo.sv
  - design/dcache_decode.sv
  - design/dcache_execute.sv
  - design/dcache_result.sv
  - design/miss_engine.sv
  - design/dcache_top.sv
  - target: test
    files:
      - verif/dcache_sva.sv
      - verif/tb_dcache.sv

/* design/dcache_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_decode
   import dcache_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_n_i,

   input  dcache_pkt_s pkt_i,
   input  logic        pkt_v_i,
   input  logic        flush_i,

   output dcache_dec_s dec_o
);

   logic        v_r;
   dcache_dec_s dec_r;
   dcache_dec_s dec_n;

   always_comb
   begin
      dec_n          = '0;
      dec_n.pkt      = pkt_i;
      dec_n.is_store = pkt_i.op inside {op_sb, op_sh, op_sw};
      dec_n.sign     = pkt_i.op inside {op_lb, op_lh};
      case (pkt_i.op)
         op_lb, op_lbu, op_sb: dec_n.size = sz_byte;
         op_lh, op_lhu, op_sh: dec_n.size = sz_half;
         default:              dec_n.size = sz_word;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         v_r <= 1'b0;
      end
      else
      begin
         v_r <= pkt_v_i && !flush_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      dec_r <= dec_n;
   end

   always_comb
   begin
      dec_o   = dec_r;
      dec_o.v = v_r;
   end

endmodule

`default_nettype wire

/* design/dcache_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_execute
   import dcache_pkg::*;
#(
   parameter int sets_p = 8
)
(
   input  logic        clk_i,
   input  logic        arst_n_i,

   input  dcache_dec_s dec_i,
   input  logic        busy_i,
   input  fill_s       fill_i,

   output miss_req_s   miss_req_o,
   output logic        complete_o,
   output logic        rollback_o,
   output result_s     res_o
);

   localparam int idx_w_lp = $clog2(sets_p);
   localparam int tag_w_lp = addr_w - line_off_w - idx_w_lp;

   logic [sets_p-1:0]   valid_r;
   logic [tag_w_lp-1:0] tag_r [sets_p];
   line_t               line_r [sets_p];

   // Outstanding read belongs to an uncached load
   logic  pend_unc_r;
   logic  unc_v_r;
   addr_t unc_addr_r;
   line_t unc_line_r;

   addr_t               line_addr;
   logic [idx_w_lp-1:0] idx;
   logic [idx_w_lp-1:0] fill_idx;
   logic [tag_w_lp-1:0] tag;
   logic [1:0]          word_sel;
   logic                hit;
   logic                unc_fill_hit;
   logic                unc_buf_hit;
   logic                complete;
   logic                send;
   mask_t               wmask;
   word_t               wdata;
   word_t               hit_word;
   word_t               merged_word;
   line_t               unc_line;

   assign line_addr = {dec_i.pkt.addr[addr_w-1:line_off_w], {line_off_w{1'b0}}};
   assign idx       = dec_i.pkt.addr[line_off_w +: idx_w_lp];
   assign tag       = dec_i.pkt.addr[addr_w-1 -: tag_w_lp];
   assign word_sel  = dec_i.pkt.addr[3:2];
   assign fill_idx  = fill_i.addr[line_off_w +: idx_w_lp];

   assign hit      = valid_r[idx] && (tag_r[idx] == tag);
   assign hit_word = line_r[idx][word_sel*word_w +: word_w];

   assign unc_fill_hit = dec_i.v && fill_i.v && pend_unc_r && (fill_i.addr == line_addr);
   assign unc_buf_hit  = unc_v_r && (unc_addr_r == line_addr);
   assign unc_line     = unc_fill_hit ? fill_i.line : unc_line_r;

   // Byte lanes and replicated store data
   always_comb
   begin
      case (dec_i.size)
         sz_byte:
         begin
            wmask = mask_t'(4'b0001 << dec_i.pkt.addr[1:0]);
            wdata = {4{dec_i.pkt.wdata[7:0]}};
         end
         sz_half:
         begin
            wmask = mask_t'(4'b0011 << {dec_i.pkt.addr[1], 1'b0});
            wdata = {2{dec_i.pkt.wdata[15:0]}};
         end
         default:
         begin
            wmask = 4'b1111;
            wdata = dec_i.pkt.wdata;
         end
      endcase
   end

   always_comb
   begin
      for (int i = 0; i < word_w/8; i++)
      begin
         merged_word[i*8 +: 8] = wmask[i] ? wdata[i*8 +: 8] : hit_word[i*8 +: 8];
      end
   end

   // Complete or poison the request in execute
   always_comb
   begin
      if (dec_i.is_store)
      begin
         complete = !busy_i;
         send     = !busy_i;
      end
      else if (dec_i.pkt.uncached)
      begin
         complete = unc_fill_hit || unc_buf_hit;
         send     = !busy_i && !complete;
      end
      else
      begin
         complete = hit;
         send     = !busy_i && !hit;
      end
   end

   assign complete_o = dec_i.v && complete;
   assign rollback_o = dec_i.v && !complete;

   assign miss_req_o.v     = dec_i.v && send;
   assign miss_req_o.write = dec_i.is_store;
   assign miss_req_o.addr  = dec_i.pkt.addr;
   assign miss_req_o.wdata = wdata;
   assign miss_req_o.wmask = wmask;

   assign res_o.v        = complete_o;
   assign res_o.is_store = dec_i.is_store;
   assign res_o.size     = dec_i.size;
   assign res_o.sign     = dec_i.sign;
   assign res_o.off      = dec_i.pkt.addr[1:0];
   assign res_o.word     = dec_i.pkt.uncached ? unc_line[word_sel*word_w +: word_w] : hit_word;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_r    <= '0;
         pend_unc_r <= 1'b0;
         unc_v_r    <= 1'b0;
      end
      else
      begin
         if (miss_req_o.v && !miss_req_o.write)
         begin
            pend_unc_r <= dec_i.pkt.uncached;
         end
         if (fill_i.v && !pend_unc_r)
         begin
            valid_r[fill_idx] <= 1'b1;
         end
         if (complete_o && dec_i.pkt.uncached && !dec_i.is_store)
         begin
            unc_v_r <= 1'b0;
         end
         // Hold an uncached fill until its load comes back around
         if (fill_i.v && pend_unc_r && !unc_fill_hit)
         begin
            unc_v_r <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (fill_i.v && !pend_unc_r)
      begin
         tag_r[fill_idx]  <= fill_i.addr[addr_w-1 -: tag_w_lp];
         line_r[fill_idx] <= fill_i.line;
      end
      if (complete_o && dec_i.is_store && hit)
      begin
         line_r[idx][word_sel*word_w +: word_w] <= merged_word;
      end
      if (fill_i.v && pend_unc_r)
      begin
         unc_addr_r <= fill_i.addr;
         unc_line_r <= fill_i.line;
      end
   end

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

   localparam int addr_w = 12;
   localparam int word_w = 32;
   localparam int line_words = 4;
   localparam int line_off_w = 4;

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [word_w-1:0] word_t;
   typedef logic [line_words*word_w-1:0] line_t;
   typedef logic [word_w/8-1:0] mask_t;
   typedef logic [1:0] size_t;
   typedef logic [1:0] boff_t;

   // Access size encodings
   localparam size_t sz_byte = 2'd0;
   localparam size_t sz_half = 2'd1;
   localparam size_t sz_word = 2'd2;

   typedef enum logic [2:0] {
      op_lb,
      op_lh,
      op_lw,
      op_lbu,
      op_lhu,
      op_sb,
      op_sh,
      op_sw
   } dcache_op_e;

   typedef struct packed {
      dcache_op_e op;
      addr_t      addr;
      word_t      wdata;
      logic       uncached;
   } dcache_pkt_s;

   typedef struct packed {
      logic        v;
      dcache_pkt_s pkt;
      logic        is_store;
      size_t       size;
      logic        sign;
   } dcache_dec_s;

   typedef struct packed {
      logic  v;
      logic  is_store;
      size_t size;
      logic  sign;
      boff_t off;
      word_t word;
   } result_s;

   typedef struct packed {
      logic  v;
      logic  write;
      addr_t addr;
      word_t wdata;
      mask_t wmask;
   } miss_req_s;

   typedef struct packed {
      logic  v;
      addr_t addr;
      line_t line;
   } fill_s;

   typedef struct packed {
      logic  write;
      addr_t addr;
      word_t wdata;
      mask_t wmask;
   } mem_cmd_s;

endpackage

`default_nettype wire

/* design/dcache_result.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_result
   import dcache_pkg::*;
(
   input  logic    clk_i,
   input  logic    arst_n_i,

   input  result_s res_i,

   output word_t   data_o,
   output logic    v_o
);

   logic  v_r;
   word_t data_r;
   word_t shifted;
   word_t data_n;

   assign shifted = res_i.word >> {res_i.off, 3'b000};

   always_comb
   begin
      case (res_i.size)
         sz_byte: data_n = {{24{res_i.sign && shifted[7]}}, shifted[7:0]};
         sz_half: data_n = {{16{res_i.sign && shifted[15]}}, shifted[15:0]};
         default: data_n = res_i.word;
      endcase
      // Stores hand back zero
      if (res_i.is_store)
      begin
         data_n = '0;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         v_r <= 1'b0;
      end
      else
      begin
         v_r <= res_i.v;
      end
   end

   always_ff @(posedge clk_i)
   begin
      data_r <= data_n;
   end

   assign v_o    = v_r;
   assign data_o = data_r;

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top
   import dcache_pkg::*;
#(
   parameter int sets_p       = 8,
   parameter int replay_els_p = 8
)
(
   input  logic        clk_i,
   input  logic        arst_n_i,

   input  dcache_pkt_s pkt_i,
   input  logic        v_i,
   output logic        ready_o,

   output word_t       data_o,
   output logic        v_o,

   output mem_cmd_s    mem_cmd_o,
   output logic        mem_cmd_v_o,
   input  logic        mem_cmd_ready_i,

   input  line_t       mem_resp_i,
   input  logic        mem_resp_v_i,
   output logic        mem_resp_yumi_o
);

   dcache_pkt_s issue_pkt;
   logic        issue_v;
   dcache_dec_s dec;
   result_s     res;
   logic        complete;
   logic        rollback;
   miss_req_s   miss_req;
   logic        busy;
   fill_s       fill;

   replay_fifo #(
      .replay_els_p(replay_els_p)
   ) u_fifo (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .pkt_i      (pkt_i),
      .v_i        (v_i),
      .ready_o    (ready_o),
      .issue_o    (issue_pkt),
      .issue_v_o  (issue_v),
      .complete_i (complete),
      .rollback_i (rollback)
   );

   // Rollback also poisons the request behind the one in execute
   dcache_decode u_decode (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .pkt_i    (issue_pkt),
      .pkt_v_i  (issue_v),
      .flush_i  (rollback),
      .dec_o    (dec)
   );

   dcache_execute #(
      .sets_p(sets_p)
   ) u_execute (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .dec_i      (dec),
      .busy_i     (busy),
      .fill_i     (fill),
      .miss_req_o (miss_req),
      .complete_o (complete),
      .rollback_o (rollback),
      .res_o      (res)
   );

   dcache_result u_result (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .res_i    (res),
      .data_o   (data_o),
      .v_o      (v_o)
   );

   miss_engine u_engine (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .miss_req_i      (miss_req),
      .busy_o          (busy),
      .fill_o          (fill),
      .mem_cmd_o       (mem_cmd_o),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_i      (mem_resp_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_yumi_o (mem_resp_yumi_o)
   );

endmodule

`default_nettype wire

/* design/miss_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module miss_engine
   import dcache_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,

   input  miss_req_s miss_req_i,
   output logic      busy_o,
   output fill_s     fill_o,

   output mem_cmd_s  mem_cmd_o,
   output logic      mem_cmd_v_o,
   input  logic      mem_cmd_ready_i,

   input  line_t     mem_resp_i,
   input  logic      mem_resp_v_i,
   output logic      mem_resp_yumi_o
);

   typedef enum logic [1:0] {
      e_idle,
      e_send,
      e_wait
   } state_e;

   state_e   state_r;
   state_e   state_n;
   mem_cmd_s cmd_r;

   assign busy_o          = (state_r != e_idle);
   assign mem_cmd_o       = cmd_r;
   assign mem_cmd_v_o     = (state_r == e_send);
   assign mem_resp_yumi_o = (state_r == e_wait) && mem_resp_v_i;

   assign fill_o.v    = mem_resp_yumi_o;
   assign fill_o.addr = cmd_r.addr;
   assign fill_o.line = mem_resp_i;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_idle:
         begin
            if (miss_req_i.v)
            begin
               state_n = e_send;
            end
         end
         e_send:
         begin
            // Writes are done once memory takes the command
            if (mem_cmd_ready_i)
            begin
               state_n = cmd_r.write ? e_idle : e_wait;
            end
         end
         e_wait:
         begin
            if (mem_resp_v_i)
            begin
               state_n = e_idle;
            end
         end
         default: state_n = e_idle;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_r <= e_idle;
      end
      else
      begin
         state_r <= state_n;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_r == e_idle && miss_req_i.v)
      begin
         cmd_r.write <= miss_req_i.write;
         cmd_r.wdata <= miss_req_i.wdata;
         cmd_r.wmask <= miss_req_i.wmask;
         // Word address for writes, line address for reads
         if (miss_req_i.write)
         begin
            cmd_r.addr <= {miss_req_i.addr[addr_w-1:2], 2'b00};
         end
         else
         begin
            cmd_r.addr <= {miss_req_i.addr[addr_w-1:line_off_w], {line_off_w{1'b0}}};
         end
      end
   end

endmodule

`default_nettype wire

/* design/replay_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module replay_fifo
   import dcache_pkg::*;
#(
   parameter int replay_els_p = 8
)
(
   input  logic        clk_i,
   input  logic        arst_n_i,

   input  dcache_pkt_s pkt_i,
   input  logic        v_i,
   output logic        ready_o,

   output dcache_pkt_s issue_o,
   output logic        issue_v_o,

   input  logic        complete_i,
   input  logic        rollback_i
);

   localparam int ptr_w_lp = $clog2(replay_els_p);

   // One extra wrap bit on each pointer tells full from empty
   logic [ptr_w_lp:0] wptr_r;
   logic [ptr_w_lp:0] iptr_r;
   logic [ptr_w_lp:0] cptr_r;
   logic [ptr_w_lp:0] used;

   dcache_pkt_s mem_r [replay_els_p];

   assign used      = wptr_r - cptr_r;
   assign ready_o   = (used < replay_els_p);
   assign issue_v_o = (iptr_r != wptr_r);
   assign issue_o   = mem_r[iptr_r[ptr_w_lp-1:0]];

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wptr_r <= '0;
         iptr_r <= '0;
         cptr_r <= '0;
      end
      else
      begin
         if (v_i && ready_o)
         begin
            wptr_r <= wptr_r + 1'b1;
         end
         // Head of the uncommitted entries is issued again
         if (rollback_i)
         begin
            iptr_r <= cptr_r;
         end
         else if (issue_v_o)
         begin
            iptr_r <= iptr_r + 1'b1;
         end
         if (complete_i)
         begin
            cptr_r <= cptr_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (v_i && ready_o)
      begin
         mem_r[wptr_r[ptr_w_lp-1:0]] <= pkt_i;
      end
   end

endmodule

`default_nettype wire

/* src.f */
design/dcache_pkg.sv
design/replay_fifo.sv
design/dcache_decode.sv
design/dcache_execute.sv
design/dcache_result.sv
design/miss_engine.sv
design/dcache_top.sv
verif/dcache_sva.sv
verif/tb_dcache.sv

/* verif/dcache_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_sva
   import dcache_pkg::*;
(
   input logic     clk_i,
   input logic     arst_n_i,
   input logic     v_o,
   input mem_cmd_s mem_cmd_o,
   input logic     mem_cmd_v_o,
   input logic     mem_cmd_ready_i,
   input logic     mem_resp_v_i,
   input logic     mem_resp_yumi_o
);

   int err_cnt = 0;

   // Command must hold while memory stalls
   a_cmd_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_o))
   else
   begin
      $error("mem_cmd_o changed or was withdrawn while mem_cmd_ready_i was low");
      err_cnt++;
   end

   a_yumi_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_resp_yumi_o |-> mem_resp_v_i)
   else
   begin
      $error("mem_resp_yumi_o high without mem_resp_v_i");
      err_cnt++;
   end

   a_quiet_in_reset: assert property (@(posedge clk_i)
      !arst_n_i |-> !v_o && !mem_cmd_v_o)
   else
   begin
      $error("v_o or mem_cmd_v_o high during reset");
      err_cnt++;
   end

endmodule

`default_nettype wire

/* verif/dcache_vectors.txt */
// test op uncached addr wdata expected
// op: 0 lb, 1 lh, 2 lw, 3 lbu, 4 lhu, 5 sb, 6 sh, 7 sw; test ff ends the list
01 0 0 0c1 00000000 ffffffc1
01 0 0 0c1 00000000 ffffffc1
01 3 0 0c2 00000000 000000c2
01 1 0 0c6 00000000 ffffc7c6
01 4 0 0ce 00000000 0000cfce
01 2 0 0c8 00000000 cbcac9c8
01 0 0 035 00000000 00000035
01 1 0 036 00000000 00003736
01 2 0 1f4 00000000 e6e7e4e5
01 3 0 1f7 00000000 000000e6
01 1 1 1f6 00000000 ffffe6e7
01 0 1 0c3 00000000 ffffffc3
02 2 0 050 00000000 53525150
02 5 0 051 000000a5 00000000
02 2 0 050 00000000 5352a550
02 6 0 052 00001234 00000000
02 4 0 052 00000000 00001234
02 2 1 050 00000000 1234a550
02 7 0 05c deadbeef 00000000
02 0 0 05f 00000000 ffffffde
02 7 0 064 87654321 00000000
02 1 0 066 00000000 ffff8765
02 5 1 067 0000005a 00000000
02 3 0 067 00000000 0000005a
02 3 1 067 00000000 0000005a
03 2 0 010 00000000 13121110
03 2 0 210 00000000 31303332
03 2 0 010 00000000 13121110
03 6 0 212 0000beef 00000000
03 2 0 210 00000000 beef3332
03 3 0 011 00000000 00000011
03 4 0 212 00000000 0000beef
03 0 0 013 00000000 00000013
04 2 0 300 00000000 30313233
04 2 0 314 00000000 24252627
04 3 0 328 00000000 0000001b
04 2 0 33c 00000000 0c0d0e0f
04 7 0 340 0badcafe 00000000
04 2 0 340 00000000 0badcafe
04 4 0 352 00000000 00006061
04 0 0 364 00000000 00000057
04 2 0 378 00000000 48494a4b
04 0 0 381 00000000 ffffffb2
04 2 0 300 00000000 30313233
04 1 1 3fe 00000000 ffffcccd
ff 0 0 000 00000000 00000000

/* verif/tb_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache
   import dcache_pkg::*;
();

   localparam int cols = 6;
   localparam int max_vec = 64;
   localparam int flood_test = 4;
   localparam int num_tests = 5;

   logic        clk_i;
   logic        arst_n_i;
   dcache_pkt_s pkt_i;
   logic        v_i;
   logic        ready_o;
   word_t       data_o;
   logic        v_o;
   mem_cmd_s    mem_cmd_o;
   logic        mem_cmd_v_o;
   logic        mem_cmd_ready_i;
   line_t       mem_resp_i;
   logic        mem_resp_v_i;
   logic        mem_resp_yumi_o;

   logic [31:0] vec_raw [0:cols*max_vec-1];
   logic [7:0]  mem_model [0:4095];
   logic [15:0] lfsr;
   int          n_vec;
   int          sent;
   int          recv;
   int          cycles;
   int          limit;
   int          full_cycles;
   int          rd_delay;
   int          cur;
   int          t_res;
   int          misc_errs;
   int          total_checks;
   int          total_errs;
   int          checks [0:num_tests-1];
   int          errs [0:num_tests-1];
   logic        rd_pend;
   addr_t       rd_addr;
   logic        run;
   logic        timed_out;
   logic        flood;
   word_t       exp_data;

   dcache_top #(
      .sets_p       (8),
      .replay_els_p (8)
   ) DUT (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .pkt_i           (pkt_i),
      .v_i             (v_i),
      .ready_o         (ready_o),
      .data_o          (data_o),
      .v_o             (v_o),
      .mem_cmd_o       (mem_cmd_o),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_i      (mem_resp_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_yumi_o (mem_resp_yumi_o)
   );

   bind dcache_top dcache_sva u_sva (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .v_o             (v_o),
      .mem_cmd_o       (mem_cmd_o),
      .mem_cmd_v_o     (mem_cmd_v_o),
      .mem_cmd_ready_i (mem_cmd_ready_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_yumi_o (mem_resp_yumi_o)
   );

   // Galois LFSR stepped once per bit
   function int rand_bits(input int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++)
      begin
         r = (r << 1) | int'(lfsr[0]);
         lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
      end
      return r;
   endfunction

   // Every byte mixes in the upper address bits so aliased lines differ
   function logic [7:0] init_byte(input addr_t a);
      return a[7:0] ^ {a[11:8], a[11:8]};
   endfunction

   function line_t read_line(input addr_t a);
      line_t l;
      for (int i = 0; i < 16; i++)
      begin
         l[8*i +: 8] = mem_model[a + i];
      end
      return l;
   endfunction

   function int test_of(input int i);
      return int'(vec_raw[cols*i][7:0]);
   endfunction

   function dcache_pkt_s make_pkt(input int i);
      dcache_pkt_s p;
      p.op       = dcache_op_e'(vec_raw[cols*i+1][2:0]);
      p.uncached = vec_raw[cols*i+2][0];
      p.addr     = addr_t'(vec_raw[cols*i+3]);
      p.wdata    = vec_raw[cols*i+4];
      return p;
   endfunction

   function string test_name(input int t);
      case (t)
         0: return "reset";
         1: return "loads";
         2: return "stores";
         3: return "alias";
         4: return "flood";
         default: return "unknown";
      endcase
   endfunction

   task report_test(input int t);
      if (t == flood_test)
      begin
         checks[t]++;
         assert (full_cycles > 0)
         else
         begin
            $display("ready_o never dropped while requests were flooding in");
            errs[t]++;
         end
      end
      $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), checks[t], errs[t]);
   endtask

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // Memory model, request driver and cycle limit
   always @(posedge clk_i)
   begin
      if (run)
      begin
         cycles++;
         if (cycles >= limit)
         begin
            timed_out = 1'b1;
         end
      end
      cur   = (sent < n_vec) ? test_of(sent) : 0;
      flood = (cur == flood_test);
      if (mem_resp_v_i && mem_resp_yumi_o)
      begin
         mem_resp_v_i <= 1'b0;
      end
      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
         if (mem_cmd_o.write)
         begin
            for (int i = 0; i < 4; i++)
            begin
               if (mem_cmd_o.wmask[i])
               begin
                  mem_model[mem_cmd_o.addr + i] = mem_cmd_o.wdata[8*i +: 8];
               end
            end
         end
         else
         begin
            rd_pend  = 1'b1;
            rd_addr  = mem_cmd_o.addr;
            rd_delay = flood ? rand_bits(3) : rand_bits(2);
         end
      end
      else if (rd_pend)
      begin
         if (rd_delay == 0)
         begin
            mem_resp_v_i <= 1'b1;
            mem_resp_i   <= read_line(rd_addr);
            rd_pend = 1'b0;
         end
         else
         begin
            rd_delay--;
         end
      end
      mem_cmd_ready_i <= flood ? (rand_bits(1) == 1) : (rand_bits(2) != 0);
      if (flood && v_i && !ready_o)
      begin
         full_cycles++;
      end
      if (v_i && ready_o)
      begin
         sent++;
      end
      if (run && sent < n_vec && (test_of(sent) == flood_test || rand_bits(2) != 0))
      begin
         v_i   <= 1'b1;
         pkt_i <= make_pkt(sent);
      end
      else
      begin
         v_i <= 1'b0;
      end
   end

   // Results are checked in request order
   always @(negedge clk_i)
   begin
      if (run && v_o)
      begin
         if (recv >= n_vec)
         begin
            $display("Extra result at %0t after all %0d requests were answered", $time, n_vec);
            misc_errs++;
         end
         else
         begin
            t_res    = test_of(recv);
            exp_data = vec_raw[cols*recv+5];
            checks[t_res]++;
            assert (data_o === exp_data)
            else
            begin
               $display("FAILED %0t data_o got %h expected %h (request %0d)",
                        $time, data_o, exp_data, recv);
               errs[t_res]++;
            end
            recv++;
            if (recv == n_vec || test_of(recv) != t_res)
            begin
               report_test(t_res);
            end
         end
      end
   end

   initial
   begin
      arst_n_i        = 1'b0;
      pkt_i           = '0;
      v_i             = 1'b0;
      mem_cmd_ready_i = 1'b0;
      mem_resp_i      = '0;
      mem_resp_v_i    = 1'b0;
      lfsr            = 16'd64290;
      run             = 1'b0;
      timed_out       = 1'b0;
      rd_pend         = 1'b0;
      rd_addr         = '0;
      rd_delay        = 0;
      sent            = 0;
      recv            = 0;
      cycles          = 0;
      full_cycles     = 0;
      misc_errs       = 0;
      n_vec           = 0;
      for (int i = 0; i < num_tests; i++)
      begin
         checks[i] = 0;
         errs[i]   = 0;
      end
      for (int a = 0; a < 4096; a++)
      begin
         mem_model[a] = init_byte(addr_t'(a));
      end
      for (int i = 0; i < cols*max_vec; i++)
      begin
         vec_raw[i] = 32'hff;
      end
      $readmemh("verif/dcache_vectors.txt", vec_raw);
      while (n_vec < max_vec && vec_raw[cols*n_vec] != 32'hff)
      begin
         n_vec++;
      end
      if (n_vec == 0)
      begin
         $display("No vectors were read from verif/dcache_vectors.txt");
         misc_errs++;
      end
      limit = n_vec * 64;

      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;
      repeat (2)
      begin
         @(negedge clk_i);
         checks[0] += 2;
         assert (v_o === 1'b0)
         else
         begin
            $display("FAILED %0t v_o got %b expected 0", $time, v_o);
            errs[0]++;
         end
         assert (mem_cmd_v_o === 1'b0)
         else
         begin
            $display("FAILED %0t mem_cmd_v_o got %b expected 0", $time, mem_cmd_v_o);
            errs[0]++;
         end
      end
      report_test(0);
      @(posedge clk_i);
      run <= 1'b1;

      wait (recv == n_vec || timed_out);
      if (timed_out)
      begin
         $display("Timeout: %0d of %0d results after %0d cycles", recv, n_vec, cycles);
         misc_errs++;
      end
      else
      begin
         // Watch for results nobody asked for
         repeat (16) @(posedge clk_i);
      end

      total_checks = 0;
      total_errs   = misc_errs + DUT.u_sva.err_cnt;
      for (int i = 0; i < num_tests; i++)
      begin
         total_checks += checks[i];
         total_errs   += errs[i];
      end
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               num_tests, total_checks, total_errs, DUT.u_sva.err_cnt);
      if (total_errs == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
